// ==== hdl/sha1_algo_pkg.sv ====
// SHA-1 algorithm definitions
`default_nettype none

package sha1_algo_pkg;

	localparam int WORD_BITS = 32;
	localparam int WINDOW_WORDS = 16;

	// words of message supplied per block, the rest is fixed padding
	localparam int DATA_WORDS = 5;

	typedef logic [WORD_BITS-1:0] word_t;

	// a sits in the least significant word
	typedef struct packed {
		word_t e;
		word_t d;
		word_t c;
		word_t b;
		word_t a;
	} state_t;

	// word 0 in the least significant position
	typedef word_t [WINDOW_WORDS-1:0] window_t;

	localparam word_t K_0 = 32'h5A827999;
	localparam word_t K_1 = 32'h6ED9EBA1;
	localparam word_t K_2 = 32'h8F1BBCDC;
	localparam word_t K_3 = 32'hCA62C1D6;

	// fixed tail of a 160-bit message
	localparam word_t PAD_WORD = 32'h80000000;
	localparam word_t LENGTH_WORD = 32'h000002a0;

	function automatic word_t round_k(input int idx);
		if (idx < 20)
			return K_0;
		else if (idx < 40)
			return K_1;
		else if (idx < 60)
			return K_2;
		return K_3;
	endfunction

	// choose, parity, majority, parity
	function automatic word_t round_f(input int idx, input word_t b, input word_t c,
		input word_t d);
		if (idx < 20)
			return d ^ (b & (c ^ d));
		else if (idx < 40)
			return b ^ c ^ d;
		else if (idx < 60)
			return (b & c) | (d & (b | c));
		return b ^ c ^ d;
	endfunction

	function automatic word_t rotl1(input word_t x);
		return {x[WORD_BITS-2:0], x[WORD_BITS-1]};
	endfunction

	function automatic word_t rotl5(input word_t x);
		return {x[WORD_BITS-6:0], x[WORD_BITS-1:WORD_BITS-5]};
	endfunction

	function automatic word_t rotl30(input word_t x);
		return {x[1:0], x[WORD_BITS-1:2]};
	endfunction

endpackage

`default_nettype wire

// ==== hdl/sha1_pipe_pkg.sv ====
// SHA-1 pipeline geometry
`default_nettype none

package sha1_pipe_pkg;

	// total SHA-1 rounds per block
	localparam int ROUNDS = 80;

	// rounds that still need the schedule expanded
	localparam int SCHEDULE_ROUNDS = 64;

	// last 16 rounds, window already complete
	localparam int TAIL_ROUNDS = ROUNDS - SCHEDULE_ROUNDS;

	// one register stage in front of the rounds
	localparam int LOADER_STAGES = 1;

	// in_valid edge to out_valid edge
	localparam int LATENCY = LOADER_STAGES + ROUNDS;

endpackage

`default_nettype wire

// ==== hdl/sha1_stage_if.sv ====
// SHA-1 stage bus
`timescale 1ns/100ps
`default_nettype none

interface sha1_stage_if;
	import sha1_algo_pkg::*;

	// block present in this stage
	logic valid;

	// working variables a to e
	state_t state;

	// sixteen message words still to come
	window_t window;

	// word the next round adds in, same as window word 0
	word_t round_word;

	modport src (
		output valid,
		output state,
		output window,
		output round_word
	);

	modport dst (
		input valid,
		input state,
		input window,
		input round_word
	);

endinterface

`default_nettype wire

// ==== hdl/sha1_block_loader.sv ====
// SHA-1 block loader
`timescale 1ns/100ps
`default_nettype none

module sha1_block_loader (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire sha1_algo_pkg::state_t ctx,
	input wire logic [sha1_algo_pkg::DATA_WORDS*sha1_algo_pkg::WORD_BITS-1:0] data,
	sha1_stage_if.src load_bus
);
	import sha1_algo_pkg::*;

	window_t padded;

	// message words, padding word, zeros, then the bit length
	always_comb begin
		padded = '0;
		for (int w = 0; w < DATA_WORDS; w++) begin
			padded[w] = data[w*WORD_BITS +: WORD_BITS];
		end
		padded[DATA_WORDS] = PAD_WORD;
		padded[WINDOW_WORDS-1] = LENGTH_WORD;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load_bus.valid <= 1'b0;
		end else begin
			load_bus.valid <= in_valid;
		end
	end

	// context goes straight in as the working state
	always_ff @(posedge clk) begin
		load_bus.state <= ctx;
		load_bus.window <= padded;
		load_bus.round_word <= padded[0];
	end

	// length word must survive into the pipeline untouched
	a_length_word: assert property (
		@(posedge clk) load_bus.valid |-> load_bus.window[WINDOW_WORDS-1] == LENGTH_WORD
	) else $error("loader window word 15 is %h, not the length word", 
		load_bus.window[WINDOW_WORDS-1]);

endmodule

`default_nettype wire

// ==== hdl/sha1_round.sv ====
// SHA-1 single round stage
`timescale 1ns/100ps
`default_nettype none

module sha1_round #(
	parameter int ROUND_INDEX = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid_in,
	input wire sha1_algo_pkg::state_t state_in,
	input wire sha1_algo_pkg::word_t word,
	output logic valid_out,
	output sha1_algo_pkg::state_t state_out
);
	import sha1_algo_pkg::*;
	import sha1_pipe_pkg::*;

	word_t f_val;
	word_t k_val;
	word_t a_next;

	// function and constant are fixed per instance
	assign f_val = round_f(ROUND_INDEX, state_in.b, state_in.c, state_in.d);
	assign k_val = round_k(ROUND_INDEX);

	// five-term add, the critical path of the stage
	assign a_next = rotl5(state_in.a) + f_val + state_in.e + k_val + word;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// variables move down one place, b is rotated on its way to c
	always_ff @(posedge clk) begin
		state_out.a <= a_next;
		state_out.b <= state_in.a;
		state_out.c <= rotl30(state_in.b);
		state_out.d <= state_in.c;
		state_out.e <= state_in.d;
	end

	a_index_range: assert property (
		@(posedge clk) ROUND_INDEX < ROUNDS
	) else $error("round index %0d is out of range", ROUND_INDEX);

	// reset is X at start-up, so only check once it has been seen low
	a_valid_known: assert property (
		@(posedge clk) disable iff (reset !== 1'b0) !$isunknown(valid_out)
	) else $error("round %0d valid_out is unknown", ROUND_INDEX);

endmodule

`default_nettype wire

// ==== hdl/sha1_schedule_rounds.sv ====
// SHA-1 rounds with schedule expansion
`timescale 1ns/100ps
`default_nettype none

module sha1_schedule_rounds (
	input wire logic clk,
	input wire logic reset,
	sha1_stage_if.dst load_bus,
	sha1_stage_if.src sched_bus
);
	import sha1_algo_pkg::*;
	import sha1_pipe_pkg::*;

	logic valid [0:SCHEDULE_ROUNDS];
	state_t state [0:SCHEDULE_ROUNDS];
	window_t window [0:SCHEDULE_ROUNDS];
	word_t round_word [0:SCHEDULE_ROUNDS];

	assign valid[0] = load_bus.valid;
	assign state[0] = load_bus.state;
	assign window[0] = load_bus.window;
	assign round_word[0] = load_bus.round_word;

	for (genvar i = 0; i < SCHEDULE_ROUNDS; i++) begin : g_stage
		word_t expanded;

		// W[t+16] from W[t], W[t+2], W[t+8], W[t+13]
		assign expanded = rotl1(window[i][0] ^ window[i][2] ^ window[i][8] ^ window[i][13]);

		sha1_round #(
			.ROUND_INDEX(i)
		) u_round (
			.clk(clk),
			.reset(reset),
			.valid_in(valid[i]),
			.state_in(state[i]),
			.word(round_word[i]),
			.valid_out(valid[i+1]),
			.state_out(state[i+1])
		);

		// window slides by one word, new word on top
		always_ff @(posedge clk) begin
			window[i+1] <= {expanded, window[i][WINDOW_WORDS-1:1]};
			round_word[i+1] <= window[i][1];
		end
	end

	// last stage hands on W[64] to W[79]
	assign sched_bus.valid = valid[SCHEDULE_ROUNDS];
	assign sched_bus.state = state[SCHEDULE_ROUNDS];
	assign sched_bus.window = window[SCHEDULE_ROUNDS];
	assign sched_bus.round_word = round_word[SCHEDULE_ROUNDS];

	a_sched_latency: assert property (
		@(posedge clk) disable iff (reset) load_bus.valid |-> ##SCHEDULE_ROUNDS sched_bus.valid
	) else $error("block did not leave the schedule rounds after %0d cycles", 
		SCHEDULE_ROUNDS);

endmodule

`default_nettype wire

// ==== hdl/sha1_tail_rounds.sv ====
// SHA-1 final sixteen rounds
`timescale 1ns/100ps
`default_nettype none

module sha1_tail_rounds (
	input wire logic clk,
	input wire logic reset,
	sha1_stage_if.dst sched_bus,
	output logic out_valid,
	output sha1_algo_pkg::state_t out_ctx
);
	import sha1_algo_pkg::*;
	import sha1_pipe_pkg::*;

	logic valid [0:TAIL_ROUNDS];
	state_t state [0:TAIL_ROUNDS];

	assign valid[0] = sched_bus.valid;
	assign state[0] = sched_bus.state;

	for (genvar i = 0; i < TAIL_ROUNDS; i++) begin : g_stage
		// only the words not yet consumed are carried on
		word_t [WINDOW_WORDS-1:i] words;

		if (i == 0) begin : g_entry
			assign words = {sched_bus.window[WINDOW_WORDS-1:1], sched_bus.round_word};
		end else begin : g_carry
			always_ff @(posedge clk) begin
				words <= g_stage[i-1].words[WINDOW_WORDS-1:i];
			end
		end

		sha1_round #(
			.ROUND_INDEX(SCHEDULE_ROUNDS + i)
		) u_round (
			.clk(clk),
			.reset(reset),
			.valid_in(valid[i]),
			.state_in(state[i]),
			.word(words[i]),
			.valid_out(valid[i+1]),
			.state_out(state[i+1])
		);
	end

	// raw working state after round 79, no context add
	assign out_valid = valid[TAIL_ROUNDS];
	assign out_ctx = state[TAIL_ROUNDS];

	a_tail_latency: assert property (
		@(posedge clk) disable iff (reset) sched_bus.valid |-> ##TAIL_ROUNDS out_valid
	) else $error("block did not reach out_valid %0d cycles after the tail entry", 
		TAIL_ROUNDS);

endmodule

`default_nettype wire

// ==== hdl/sha1_pipeline_top.sv ====
// SHA-1 pipelined compression core
`timescale 1ns/100ps
`default_nettype none

module sha1_pipeline_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire sha1_algo_pkg::state_t ctx,
	input wire logic [sha1_algo_pkg::DATA_WORDS*sha1_algo_pkg::WORD_BITS-1:0] data,
	output logic out_valid,
	output sha1_algo_pkg::state_t out_ctx
);

	// loader to schedule rounds
	sha1_stage_if load_bus ();

	// schedule rounds to tail rounds
	sha1_stage_if sched_bus ();

	sha1_block_loader u_loader (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.ctx(ctx),
		.data(data),
		.load_bus(load_bus)
	);

	sha1_schedule_rounds u_schedule (
		.clk(clk),
		.reset(reset),
		.load_bus(load_bus),
		.sched_bus(sched_bus)
	);

	sha1_tail_rounds u_tail (
		.clk(clk),
		.reset(reset),
		.sched_bus(sched_bus),
		.out_valid(out_valid),
		.out_ctx(out_ctx)
	);

endmodule

`default_nettype wire

// ==== testbench/sha1_ref_model.svh ====
// SHA-1 reference model
`ifndef SHA1_REF_MODEL_SVH
`define SHA1_REF_MODEL_SVH

// rotate a word left by n places
function automatic word_t rotate_left(input word_t x, input int n);
	return (x << n) | (x >> (32 - n));
endfunction

// working state after all 80 rounds, no feed-forward add
function automatic state_t sha1_compress(input state_t init, input msg_t msg);
	word_t w [0:79];
	word_t a;
	word_t b;
	word_t c;
	word_t d;
	word_t e;
	word_t f;
	word_t k;
	word_t t;
	state_t r;
	for (int i = 0; i < 16; i++)
		w[i] = 32'h0;
	for (int i = 0; i < 5; i++)
		w[i] = msg[i*32 +: 32];
	// one bit after the message, length field 0x2a0 in the last word
	w[5] = 32'h80000000;
	w[15] = 32'h000002a0;
	for (int i = 16; i < 80; i++)
		w[i] = rotate_left(w[i-3] ^ w[i-8] ^ w[i-14] ^ w[i-16], 1);
	a = init.a;
	b = init.b;
	c = init.c;
	d = init.d;
	e = init.e;
	for (int i = 0; i < 80; i++) begin
		if (i < 20) begin
			f = (b & c) | (~b & d);
			k = 32'h5a827999;
		end else if (i < 40) begin
			f = b ^ c ^ d;
			k = 32'h6ed9eba1;
		end else if (i < 60) begin
			f = (b & c) | (b & d) | (c & d);
			k = 32'h8f1bbcdc;
		end else begin
			f = b ^ c ^ d;
			k = 32'hca62c1d6;
		end
		t = rotate_left(a, 5) + f + e + k + w[i];
		e = d;
		d = c;
		c = rotate_left(b, 30);
		b = a;
		a = t;
	end
	r.a = a;
	r.b = b;
	r.c = c;
	r.d = d;
	r.e = e;
	return r;
endfunction

`endif

// ==== testbench/tb_sha1_pipeline.sv ====
// SHA-1 pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module tb_sha1_pipeline;
	import sha1_algo_pkg::*;
	import sha1_pipe_pkg::*;

	typedef logic [DATA_WORDS*WORD_BITS-1:0] msg_t;

	`include "sha1_ref_model.svh"

	localparam int RANDOM_BLOCKS = 200;
	localparam int GAP_CYCLES = 300;
	localparam int DRAIN_TIMEOUT = 200;

	logic clk;
	logic reset;
	logic in_valid;
	state_t ctx;
	msg_t data;
	logic out_valid;
	state_t out_ctx;

	int seed = 95580;
	int cycle = 0;
	int pending = 0;
	int head_tag = 0;
	state_t head_exp = '0;
	int results = 0;
	int dropped = 0;
	int value_errors = 0;
	int timing_errors = 0;
	int timeouts = 0;
	state_t exp_q [$];
	int tag_q [$];

	sha1_pipeline_top dut0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.ctx(ctx),
		.data(data),
		.out_valid(out_valid),
		.out_ctx(out_ctx)
	);

	always #10 clk = ~clk;

	// scoreboard follows what the DUT samples on each edge
	always @(posedge clk) begin
		if (out_valid === 1'b1 && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
			void'(tag_q.pop_front());
			results++;
		end
		// reset wipes every block still in flight
		if (reset) begin
			dropped += exp_q.size();
			exp_q.delete();
			tag_q.delete();
		end else if (in_valid) begin
			exp_q.push_back(sha1_compress(ctx, data));
			tag_q.push_back(cycle);
		end
		pending = exp_q.size();
		if (pending > 0) begin
			head_exp = exp_q[0];
			head_tag = tag_q[0];
		end
		cycle++;
	end

	a_result: assert property (@(posedge clk) out_valid && pending > 0 |-> out_ctx == head_exp)
		else begin
			value_errors++;
			$display("FAILED out_ctx: got %h expected %h", $sampled(out_ctx), $sampled(head_exp));
		end

	a_latency: assert property (
		@(posedge clk) out_valid && pending > 0 |-> cycle - head_tag == LATENCY
	) else begin
		timing_errors++;
		$display("FAILED latency: got %h expected %h", $sampled(cycle - head_tag), LATENCY);
	end

	a_no_spurious: assert property (@(posedge clk) out_valid |-> pending > 0)
		else begin
			timing_errors++;
			$display("out_valid went high with no block waiting for a result");
		end

	// a block that is due must show up
	a_missing: assert property (
		@(posedge clk) pending > 0 && cycle - head_tag == LATENCY |-> out_valid
	) else begin
		timing_errors++;
		$display("out_valid stayed low on the cycle a result was due");
	end

	a_reset_quiet: assert property (@(posedge clk) $past(reset) |-> out_valid !== 1'b1)
		else begin
			timing_errors++;
			$display("out_valid was high right after a reset edge");
		end

	task automatic drive(input logic v, input state_t c, input msg_t d);
		@(posedge clk);
		in_valid <= v;
		ctx <= c;
		data <= d;
	endtask

	function automatic state_t random_state();
		state_t s;
		s.a = $random(seed);
		s.b = $random(seed);
		s.c = $random(seed);
		s.d = $random(seed);
		s.e = $random(seed);
		return s;
	endfunction

	function automatic msg_t random_msg();
		msg_t m;
		for (int i = 0; i < DATA_WORDS; i++)
			m[i*WORD_BITS +: WORD_BITS] = $random(seed);
		return m;
	endfunction

	task automatic hold_reset(input int cycles);
		@(posedge clk);
		reset <= 1'b1;
		repeat (cycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	// idle the input, then wait until every block has come out
	task automatic wait_for_drain();
		int waited;
		waited = 0;
		drive(1'b0, '0, '0);
		@(negedge clk);
		while (pending > 0 && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (pending > 0) begin
			timeouts++;
			$display("timeout: %0d blocks still in flight after %0d cycles", pending, waited);
		end
	endtask

	initial begin
		state_t iv;
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		ctx = '0;
		data = '0;
		iv.a = 32'h67452301;
		iv.b = 32'hefcdab89;
		iv.c = 32'h98badcfe;
		iv.d = 32'h10325476;
		iv.e = 32'hc3d2e1f0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// standard initial value, zero message
		drive(1'b1, iv, '0);
		wait_for_drain();

		// one block every cycle fills the whole pipeline
		repeat (RANDOM_BLOCKS) drive(1'b1, random_state(), random_msg());
		wait_for_drain();

		// idle cycles mixed in
		repeat (GAP_CYCLES) drive(($random(seed) & 3) != 0, random_state(), random_msg());
		wait_for_drain();

		// reset with a full pipeline and results coming out
		repeat (100) drive(1'b1, random_state(), random_msg());
		hold_reset(5);
		repeat (20) drive(($random(seed) & 1) != 0, random_state(), random_msg());
		wait_for_drain();

		$display("results %0d, dropped %0d, value errors %0d, timing errors %0d, timeouts %0d",
			results, dropped, value_errors, timing_errors, timeouts);
		if (value_errors + timing_errors + timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+testbench
hdl/sha1_algo_pkg.sv
hdl/sha1_pipe_pkg.sv
hdl/sha1_stage_if.sv
hdl/sha1_block_loader.sv
hdl/sha1_round.sv
hdl/sha1_schedule_rounds.sv
hdl/sha1_tail_rounds.sv
hdl/sha1_pipeline_top.sv
testbench/tb_sha1_pipeline.sv
